// ==== source/serdes_pkg.sv ====
//****************************************
// SERDES loopback shared definitions
// Word size, training pattern, lock and startup wait
//****************************************
`default_nettype none

package serdes_pkg;

    //****************************************
    // Sizes and timing constants
    //****************************************
    localparam int SERDES_WIDTH = 10;      // Default word width
    localparam int LOCK_WORDS   = 4;       // Training words needed for lock
    localparam int WAIT_CYCLES  = 255;     // Bit clocks before ready may rise

    // Five ones then five zeros, no rotation matches itself
    localparam logic [SERDES_WIDTH-1:0] TRAIN_WORD = 10'b11111_00000;

    //****************************************
    // Receive state
    //****************************************
    typedef enum logic [1:0] {
        RX_WAIT = 2'd0,                    // Counting startup cycles
        RX_LOCK = 2'd1,                    // Waiting on the aligner
        RX_RUN  = 2'd2                     // Ready, words pass through
    } rx_state_t;

endpackage : serdes_pkg

`default_nettype wire

// ==== source/rx_word_if.sv ====
//****************************************
// Receive-side word bus
// Word, word strobe, lock and ready levels
//****************************************
`default_nettype none

interface rx_word_if
    import serdes_pkg::*;
#(
    parameter int WIDTH = SERDES_WIDTH
);
    logic [WIDTH-1:0] word;                // Assembled word, earliest bit in MSB
    logic             word_valid;          // One-cycle strobe per word
    logic             locked;              // Sticky training lock
    logic             ready;               // Receive path running

    // Deserializer side
    modport deser   (output word, output word_valid);

    // Training detector
    modport aligner (input word, input word_valid, output locked);

    // Startup gate and capture
    modport gate    (input word, input word_valid, input locked, output ready);

endinterface : rx_word_if

`default_nettype wire

// ==== source/bit_deserializer.sv ====
//****************************************
// Bit deserializer
// Shifts serial bits into WIDTH-bit words, with bitslip
// moving the word boundary by one bit
//****************************************
`default_nettype none

module bit_deserializer #(
    parameter int WIDTH = 10
) (
    input  logic       clkGHz_clkbuf,
    input  logic       reset_buf_n,
    input  logic       enable,             // Shift one bit per clock when high
    input  logic       serial_in,
    input  logic       bitslip,            // High for one cycle per slip
    rx_word_if.deser   rx
);

    localparam int CW = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic [WIDTH-1:0] shift_q;             // Incoming bits, newest in LSB
    logic [CW-1:0]    bit_cnt;             // Position inside the current word
    logic             boundary;            // Last bit of a word arrives now
    logic             advance;             // Counter steps this cycle

    //****************************************
    // Boundary tracking
    //****************************************
    // Slip holds the counter, so one word gets WIDTH+1 bits
    assign advance  = enable & ~bitslip;
    assign boundary = advance && (bit_cnt == CW'(WIDTH - 1));

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt <= '0;
        end else if (boundary) begin
            bit_cnt <= '0;                 // Wrap at word end
        end else if (advance) begin
            bit_cnt <= bit_cnt + CW'(1);
        end
    end

    //****************************************
    // Shift register and word output
    //****************************************
    always_ff @(posedge clkGHz_clkbuf) begin
        if (enable) begin
            shift_q <= {shift_q[WIDTH-2:0], serial_in}; // Earliest bit drifts to MSB
        end
    end

    always_ff @(posedge clkGHz_clkbuf) begin
        if (boundary) begin
            rx.word <= {shift_q[WIDTH-2:0], serial_in}; // Include the bit arriving now
        end
    end

    // Strobe lines up with the freshly registered word
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            rx.word_valid <= 1'b0;
        end else begin
            rx.word_valid <= boundary;     // One-cycle pulse
        end
    end

endmodule : bit_deserializer

`default_nettype wire

// ==== source/word_aligner.sv ====
//****************************************
// Word aligner
// Counts back-to-back training words, sticky lock
//****************************************
`default_nettype none

module word_aligner
    import serdes_pkg::*;
#(
    parameter int LOCK_COUNT = LOCK_WORDS
) (
    input  logic       clkGHz_clkbuf,
    input  logic       reset_buf_n,
    rx_word_if.aligner rx
);

    localparam int CCW = $clog2(LOCK_COUNT + 1);

    logic [CCW-1:0] match_cnt;             // Consecutive training words seen
    logic           is_train;              // Current word is the pattern
    logic           last_needed;           // This strobe completes the run

    assign is_train    = (rx.word == TRAIN_WORD);
    assign last_needed = rx.word_valid && is_train &&
                         (match_cnt == CCW'(LOCK_COUNT - 1));

    //****************************************
    // Run counter
    //****************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            match_cnt <= '0;
        end else if (rx.word_valid) begin
            if (!is_train) begin
                match_cnt <= '0;           // Any mismatch restarts the run
            end else if (match_cnt != CCW'(LOCK_COUNT)) begin
                match_cnt <= match_cnt + CCW'(1); // Saturates at LOCK_COUNT
            end
        end
    end

    //****************************************
    // Lock flag
    //****************************************
    // Rises one cycle after the LOCK_COUNT-th match, held until reset
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            rx.locked <= 1'b0;
        end else if (last_needed) begin
            rx.locked <= 1'b1;
        end
    end

endmodule : word_aligner

`default_nettype wire

// ==== source/rx_ready_gate.sv ====
//****************************************
// Receive ready gate
// Startup wait plus lock give ready, then words
// are captured and handed to the serializer
//****************************************
`default_nettype none

module rx_ready_gate
    import serdes_pkg::*;
#(
    parameter int WIDTH    = SERDES_WIDTH,
    parameter int WAIT_LEN = WAIT_CYCLES
) (
    input  logic             clkGHz_clkbuf,
    input  logic             reset_buf_n,
    rx_word_if.gate          rx,
    output logic [WIDTH-1:0] capture_word,  // Held for the serializer
    output logic             word_load,     // Pulse, one cycle after strobe
    output rx_state_t        ready_state
);

    localparam int WCW = $clog2(WAIT_LEN + 1);

    logic [WCW-1:0] wait_cnt;              // Saturating startup counter
    logic           wait_done;
    rx_state_t      state_nxt;
    logic           take_word;             // Strobe seen while running

    assign wait_done = (wait_cnt == WCW'(WAIT_LEN));
    assign take_word = rx.word_valid & rx.ready;
    assign rx.ready  = (ready_state == RX_RUN);

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            wait_cnt <= '0;
        end else if (!wait_done) begin
            wait_cnt <= wait_cnt + WCW'(1);
        end
    end

    //****************************************
    // Receive FSM
    //****************************************
    always_comb begin
        state_nxt = ready_state;
        case (ready_state)
            RX_WAIT: if (wait_done) state_nxt = rx.locked ? RX_RUN : RX_LOCK; // Skip if locked
            RX_LOCK: if (rx.locked) state_nxt = RX_RUN;
            RX_RUN:  state_nxt = RX_RUN;   // Stays until reset
            default: state_nxt = RX_WAIT;
        endcase
    end

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            ready_state <= RX_WAIT;
            word_load   <= 1'b0;
        end else begin
            ready_state <= state_nxt;
            word_load   <= take_word;      // Lines up with capture_word
        end
    end

    always_ff @(posedge clkGHz_clkbuf) begin
        if (take_word) capture_word <= rx.word;
    end

endmodule : rx_ready_gate

`default_nettype wire

// ==== source/bit_serializer.sv ====
//****************************************
// Bit serializer
// Shifts loaded words out MSB first with output enable
//****************************************
`default_nettype none

module bit_serializer #(
    parameter int WIDTH = 10
) (
    input  logic             clkGHz_clkbuf,
    input  logic             reset_buf_n,
    input  logic             enable,        // Shift one bit per clock when high
    input  logic [WIDTH-1:0] capture_word,
    input  logic             word_load,
    output logic             serial_out,
    output logic             data_oe
);

    localparam int LW = $clog2(WIDTH + 1);

    logic [WIDTH-1:0] shift_q;             // MSB is the bit on the line
    logic [WIDTH-1:0] pend_word;           // Word loaded while line was busy
    logic             pend_full;
    logic [LW-1:0]    bits_left;           // Bits still to send, MSB included
    logic             loaded;              // At least one word went out
    logic             load_sh;             // Shift register refills this cycle
    logic             stash;               // word_load parks in pend_word

    //****************************************
    // Refill control
    //****************************************
    // Refill once the last bit is on the line, older pending word first
    assign load_sh = enable && (bits_left < LW'(2)) && (pend_full || word_load);
    assign stash   = word_load && !(load_sh && !pend_full);

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bits_left <= '0;
            pend_full <= 1'b0;
            loaded    <= 1'b0;
        end else begin
            if (load_sh) begin
                bits_left <= LW'(WIDTH);
                loaded    <= 1'b1;
            end else if (enable && bits_left != '0) begin
                bits_left <= bits_left - LW'(1);
            end
            if (stash) begin
                pend_full <= 1'b1;
            end else if (load_sh) begin
                pend_full <= 1'b0;         // Pending word consumed
            end
        end
    end

    //****************************************
    // Data path
    //****************************************
    always_ff @(posedge clkGHz_clkbuf) begin
        if (load_sh) begin
            shift_q <= pend_full ? pend_word : capture_word;
        end else if (enable) begin
            shift_q <= {shift_q[WIDTH-2:0], 1'b0}; // Next bit to MSB
        end
        if (stash) pend_word <= capture_word;
    end

    assign data_oe    = enable & loaded;
    assign serial_out = data_oe & shift_q[WIDTH-1]; // Quiet line when disabled

endmodule : bit_serializer

`default_nettype wire

// ==== source/serdes_loopback_top.sv ====
//****************************************
// SERDES loopback top
// Deserializer, aligner, ready gate and serializer
//****************************************
`default_nettype none

module serdes_loopback_top
    import serdes_pkg::*;
#(
    parameter int WIDTH = SERDES_WIDTH
) (
    input  logic      clkGHz_clkbuf,
    input  logic      reset_buf_n,         // Async, active low
    input  logic      enable_n,            // Active low enable
    input  logic      serial_in,
    input  logic      bitslip_n,           // Active low slip request
    output logic      serial_out,
    output logic      data_oe,
    output logic      ready,
    output rx_state_t ready_state
);

    logic             enable;
    logic             bitslip;
    logic [WIDTH-1:0] capture_word;        // Gate to serializer
    logic             word_load;

    assign enable  = ~enable_n;
    assign bitslip = ~bitslip_n;

    rx_word_if #(.WIDTH(WIDTH)) rx_bus ();

    assign ready = rx_bus.ready;

    //****************************************
    // Receive path
    //****************************************
    bit_deserializer #(.WIDTH(WIDTH)) deser0 (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .enable        (enable),
        .serial_in     (serial_in),
        .bitslip       (bitslip),
        .rx            (rx_bus.deser)
    );

    word_aligner #(.LOCK_COUNT(LOCK_WORDS)) aligner0 (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .rx            (rx_bus.aligner)
    );

    rx_ready_gate #(.WIDTH(WIDTH), .WAIT_LEN(WAIT_CYCLES)) gate0 (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .rx            (rx_bus.gate),
        .capture_word  (capture_word),
        .word_load     (word_load),
        .ready_state   (ready_state)   // Status out
    );

    // Transmit path
    bit_serializer #(.WIDTH(WIDTH)) ser0 (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .enable        (enable),
        .capture_word  (capture_word),
        .word_load     (word_load),
        .serial_out    (serial_out),
        .data_oe       (data_oe)
    );

endmodule : serdes_loopback_top

`default_nettype wire

// ==== testbench/serdes_loopback_asserts.sv ====
//****************************************
// SERDES loopback assertions
// Strobe spacing and ready against lock
//****************************************
`default_nettype none

module serdes_loopback_asserts
    import serdes_pkg::*;
#(
    parameter int WIDTH = SERDES_WIDTH
) (
    input logic clkGHz_clkbuf,
    input logic reset_buf_n,
    input logic word_valid,
    input logic locked,
    input logic ready
);

    // Next strobe no sooner than WIDTH cycles
    strobe_gap: assert property (@(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        word_valid |=> !word_valid [*(WIDTH-1)])
        else $error("word_valid strobes closer than WIDTH cycles");

    ready_needs_lock: assert property (@(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        $rose(ready) |-> locked)
        else $error("ready rose without locked");

endmodule : serdes_loopback_asserts

// Receive-side checks on the startup gate
bind rx_ready_gate serdes_loopback_asserts #(.WIDTH(WIDTH)) gate_chk (
    .clkGHz_clkbuf (clkGHz_clkbuf),
    .reset_buf_n   (reset_buf_n),
    .word_valid    (rx.word_valid),
    .locked        (rx.locked),
    .ready         (rx.ready)
);

`default_nettype wire

// ==== testbench/serdes_loopback_tb.sv ====
//****************************************
// SERDES loopback testbench
// File-driven bit stream, bitslip search and
// serial loopback word checking
//****************************************
`default_nettype none

module serdes_loopback_tb
    import serdes_pkg::*;
();

    localparam int W         = SERDES_WIDTH;
    localparam int SLIP_GAP  = (LOCK_WORDS + 2) * W;  // Room for a full lock run
    localparam int STRETCH   = 3 * W;                 // Enable held off this long
    localparam int DRAIN_MAX = 6 * W;

    logic      clkGHz_clkbuf;
    logic      reset_buf_n;
    logic      enable_n;
    logic      serial_in;
    logic      bitslip_n;
    logic      serial_out;
    logic      data_oe;
    logic      ready;
    rx_state_t ready_state;

    logic [15:0] vec [0:31];               // Run length, offset, count, payload
    int          run_len;
    int          offset;
    int          n_pay;
    int          seed;
    int          cyc;                      // Clocks since reset release
    int          slips;
    int          next_slip;
    int          n_matched;                // Payload words seen on serial_out
    int          out_bits;
    logic [W-1:0] out_word;
    logic        out_started;
    logic        s_ready;                  // Sampled DUT outputs
    logic        s_oe;
    logic        s_out;
    rx_state_t   s_state;

    serdes_loopback_top #(.WIDTH(W)) dut0 (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .enable_n      (enable_n),
        .serial_in     (serial_in),
        .bitslip_n     (bitslip_n),
        .serial_out    (serial_out),
        .data_oe       (data_oe),
        .ready         (ready),
        .ready_state   (ready_state)
    );

    initial begin
        clkGHz_clkbuf = 1'b0;
        forever #10 clkGHz_clkbuf = ~clkGHz_clkbuf;
    end

    //****************************************
    // Checks
    //****************************************
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_state(input string name, input rx_state_t got, input rx_state_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] t=%0t %s got %s expected %s",
                                $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic check_word(input string name, input logic [W-1:0] got,
                              input logic [W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // Builds whole words from serial_out bits, MSB first
    task automatic collect_bit(input logic b);
        out_word = {out_word[W-2:0], b};
        out_bits++;
        if (out_bits == W) begin
            out_bits = 0;
            if (out_word != TRAIN_WORD) out_started = 1'b1; // Echoed training comes first
            if (out_started && n_matched < n_pay) begin
                check_word("serial_out word", out_word, W'(vec[3 + n_matched]));
                n_matched++;
            end
        end
    endtask

    //****************************************
    // Stimulus
    //****************************************
    // Samples outputs mid-cycle, then drives on the rising edge
    task automatic tick(input logic din, input logic en_n_v, input logic slip_n_v);
        @(negedge clkGHz_clkbuf);
        cyc++;
        s_ready = ready;
        s_oe    = data_oe;
        s_out   = serial_out;
        s_state = ready_state;
        if (cyc <= WAIT_CYCLES) begin      // Startup wait still running
            check_bit("ready", s_ready, 1'b0);
            check_state("ready_state", s_state, RX_WAIT);
        end
        if (!s_oe) check_bit("serial_out", s_out, 1'b0);
        else collect_bit(s_out);
        @(posedge clkGHz_clkbuf);
        serial_in <= din;
        enable_n  <= en_n_v;
        bitslip_n <= slip_n_v;
    endtask

    // One stream bit, with a slip pulse while lock is still missing
    task automatic send_bit(input logic b);
        logic slip_n_v;
        slip_n_v = 1'b1;
        if (!s_ready && cyc > WAIT_CYCLES + 1 && cyc >= next_slip) begin
            check_state("ready_state", s_state, RX_LOCK); // Wait over, lock missing
            slip_n_v  = 1'b0;
            slips++;
            next_slip = cyc + SLIP_GAP;
        end
        tick(b, 1'b0, slip_n_v);
    endtask

    task automatic hold_enable();
        int i;
        for (i = 0; i < STRETCH; i++) begin
            tick(1'($random(seed)), 1'b1, 1'b1); // Line value is ignored
            if (i == 0) check_bit("data_oe", s_oe, 1'b1);
            else check_bit("data_oe", s_oe, 1'b0);
        end
    endtask

    //****************************************
    // Main sequence
    //****************************************
    initial begin
        int i;
        int b;
        int w;
        int n_train;
        seed        = 84;
        reset_buf_n = 1'b0;
        enable_n    = 1'b1;
        serial_in   = 1'b0;
        bitslip_n   = 1'b1;
        cyc         = 0;
        slips       = 0;
        next_slip   = 0;
        n_matched   = 0;
        out_bits    = 0;
        out_word    = '0;
        out_started = 1'b0;
        s_ready     = 1'b0;
        s_oe        = 1'b0;
        s_out       = 1'b0;
        s_state     = RX_WAIT;
        $readmemh("testbench/serdes_input_vectors.txt", vec);
        run_len = int'(vec[0]);
        offset  = int'(vec[1]);
        n_pay   = int'(vec[2]);
        if (offset >= W || n_pay < 3 || n_pay > 29) begin
            abort_run("Input vector file has a bad offset or payload count");
        end

        repeat (8) @(posedge clkGHz_clkbuf);
        check_bit("ready", ready, 1'b0);   // Reset values
        check_bit("data_oe", data_oe, 1'b0);
        check_bit("serial_out", serial_out, 1'b0);
        check_state("ready_state", ready_state, RX_WAIT);
        reset_buf_n <= 1'b1;

        for (i = 0; i < offset; i++) send_bit(1'b0); // Push pattern off the boundary

        n_train = 0;
        while (!s_ready) begin
            if (n_train == run_len) abort_run("ready did not rise within the training run");
            if (slips > W) abort_run("no lock after WIDTH bitslip pulses");
            for (b = W - 1; b >= 0; b--) send_bit(TRAIN_WORD[b]);
            n_train++;
        end
        check_state("ready_state", s_state, RX_RUN);
        // Each slip delays the boundary by one bit
        if (slips != offset) begin
            abort_run($sformatf("[ERROR] t=%0t bitslip pulses got %0d expected %0d",
                                $time, slips, offset));
        end

        for (w = 0; w < n_pay; w++) begin
            for (b = W - 1; b >= 0; b--) begin
                if (w == 2 && b == W / 2) hold_enable(); // Pause mid-word
                send_bit(vec[3 + w][b]);
            end
        end

        i = 0;
        while (n_matched < n_pay) begin
            if (i == DRAIN_MAX) abort_run("payload words did not all come back on serial_out");
            send_bit(1'($random(seed)));
            i++;
        end
        $display("Testbench passed");
        $finish;
    end

endmodule : serdes_loopback_tb

`default_nettype wire

// ==== testbench/serdes_input_vectors.txt ====
// Line 1 training run length in words, line 2 bit offset, line 3 payload count
// Remaining lines are payload words in hex, sent MSB first
0060
0003
0008
2A5
0F3
1C6
35A
099
21E
3C1
14B

// ==== src.f ====
source/serdes_pkg.sv
source/rx_word_if.sv
source/bit_deserializer.sv
source/word_aligner.sv
source/rx_ready_gate.sv
source/bit_serializer.sv
source/serdes_loopback_top.sv
testbench/serdes_loopback_asserts.sv
testbench/serdes_loopback_tb.sv

// ==== Bender.yml ====
package:
  name: serdes_loopback

sources:
  - files:
      - source/serdes_pkg.sv
      - source/rx_word_if.sv
      - source/bit_deserializer.sv
      - source/word_aligner.sv
      - source/rx_ready_gate.sv
      - source/bit_serializer.sv
      - source/serdes_loopback_top.sv
  - target: test
    files:
      - testbench/serdes_loopback_asserts.sv
      - testbench/serdes_loopback_tb.sv
